/* include/risc8_defs.svh */
`ifndef RISC8_DEFS_SVH
`define RISC8_DEFS_SVH

// datapath word.
`define RISC8_WORD_W 8

// apb bus widths.
`define RISC8_PDATA_W 16
`define RISC8_PADDR_W 4

// low bits of rb used as a shift count.
`define RISC8_SHAMT_W 3

// write port for instructions.
`define RISC8_ADDR_INSTR 0

// read map: 0 to 3 are r0 to r3, then ah.
`define RISC8_ADDR_AH 4

`endif

/* source/risc8_pkg.sv */
`include "risc8_defs.svh"

package risc8_pkg;

        typedef logic [`RISC8_WORD_W-1:0]  word_t;
        typedef logic [`RISC8_PDATA_W-1:0] pdata_t;
        typedef logic [1:0]                reg_addr_t;

        // upper nibble of the instruction byte.
        typedef enum logic [3:0] {
                CPY   = 4'd0,
                MOVE  = 4'd1,
                ADD   = 4'd2,
                SUB   = 4'd3,
                AND   = 4'd4,
                OR    = 4'd5,
                XOR   = 4'd6,
                MUL   = 4'd7,
                SLL   = 4'd8,
                SRL   = 4'd9,
                SRA   = 4'd10,
                INC   = 4'd11,
                DEC   = 4'd12,
                GETAH = 4'd13
        } opcode_t;

        typedef enum logic [3:0] {
                ALU_NONE,
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_MUL,
                ALU_SL,
                ALU_SR,
                ALU_RA
        } alu_op_t;

        // second operand source.
        typedef enum logic [1:0] {
                SB_NONE,
                SB_REG,
                SB_1,
                SB_IMM
        } selb_t;

        // writeback source for ra.
        typedef enum logic [2:0] {
                SR_NONE,
                SR_IMM,
                SR_REG,
                SR_ALUL,
                SR_ALUH
        } selr_t;

        typedef struct packed {
                alu_op_t alu_op;
                selb_t   selb;
                selr_t   selr;
                logic    rw_en;
                logic    ah_en;
        } ctrl_t;

endpackage

/* source/risc8_decoder.sv */
module risc8_decoder import risc8_pkg::*; (
        input  word_t     instr,
        output ctrl_t     ctrl,
        output reg_addr_t ra,
        output reg_addr_t rb,
        output logic      illegal
);

        opcode_t opcode;

        assign opcode = opcode_t'(instr[7:4]);
        assign ra     = reg_addr_t'(instr[3:2]);
        assign rb     = reg_addr_t'(instr[1:0]);

        // destination is always ra.
        always_comb begin
                ctrl.alu_op = ALU_NONE;
                ctrl.selb   = SB_NONE;
                ctrl.selr   = SR_NONE;
                ctrl.rw_en  = 1'b1;
                ctrl.ah_en  = 1'b0;
                illegal     = 1'b0;
                case (opcode)
                        CPY: begin
                                ctrl.selb = SB_IMM;
                                ctrl.selr = SR_IMM;
                        end
                        MOVE: begin
                                ctrl.selr = SR_REG;
                        end
                        ADD: begin
                                ctrl.alu_op = ALU_ADD;
                                ctrl.selb   = SB_REG;
                                ctrl.selr   = SR_ALUL;
                        end
                        SUB: begin
                                ctrl.alu_op = ALU_SUB;
                                ctrl.selb   = SB_REG;
                                ctrl.selr   = SR_ALUL;
                        end
                        AND: begin
                                ctrl.alu_op = ALU_AND;
                                ctrl.selb   = SB_REG;
                                ctrl.selr   = SR_ALUL;
                        end
                        OR: begin
                                ctrl.alu_op = ALU_OR;
                                ctrl.selb   = SB_REG;
                                ctrl.selr   = SR_ALUL;
                        end
                        XOR: begin
                                ctrl.alu_op = ALU_XOR;
                                ctrl.selb   = SB_REG;
                                ctrl.selr   = SR_ALUL;
                        end
                        MUL: begin
                                ctrl.alu_op = ALU_MUL;
                                ctrl.selb   = SB_REG;
                                ctrl.selr   = SR_ALUL;
                                ctrl.ah_en  = 1'b1;
                        end
                        SLL: begin
                                ctrl.alu_op = ALU_SL;
                                ctrl.selb   = SB_REG;
                                ctrl.selr   = SR_ALUL;
                        end
                        SRL: begin
                                ctrl.alu_op = ALU_SR;
                                ctrl.selb   = SB_REG;
                                ctrl.selr   = SR_ALUL;
                        end
                        SRA: begin
                                ctrl.alu_op = ALU_RA;
                                ctrl.selb   = SB_REG;
                                ctrl.selr   = SR_ALUL;
                        end
                        // inc and dec reuse the adder with a constant one.
                        INC: begin
                                ctrl.alu_op = ALU_ADD;
                                ctrl.selb   = SB_1;
                                ctrl.selr   = SR_ALUL;
                        end
                        DEC: begin
                                ctrl.alu_op = ALU_SUB;
                                ctrl.selb   = SB_1;
                                ctrl.selr   = SR_ALUL;
                        end
                        GETAH: begin
                                ctrl.selr = SR_ALUH;
                        end
                        default: begin
                                ctrl.rw_en = 1'b0;
                                illegal    = 1'b1;
                        end
                endcase
        end

endmodule

/* source/risc8_alu.sv */
`include "risc8_defs.svh"

module risc8_alu import risc8_pkg::*; (
        input  alu_op_t alu_op,
        input  word_t   a,
        input  word_t   b,
        output word_t   alu_lo,
        output word_t   alu_hi
);

        logic [2*`RISC8_WORD_W-1:0] product;
        logic [`RISC8_SHAMT_W-1:0]  shamt;

        // full unsigned product, split below.
        assign product = a * b;
        assign shamt   = b[`RISC8_SHAMT_W-1:0];

        always_comb begin
                alu_hi = '0;
                case (alu_op)
                        ALU_ADD: begin
                                alu_lo = a + b;
                        end
                        ALU_SUB: begin
                                alu_lo = a - b;
                        end
                        ALU_AND: begin
                                alu_lo = a & b;
                        end
                        ALU_OR: begin
                                alu_lo = a | b;
                        end
                        ALU_XOR: begin
                                alu_lo = a ^ b;
                        end
                        ALU_MUL: begin
                                alu_lo = product[`RISC8_WORD_W-1:0];
                                alu_hi = product[2*`RISC8_WORD_W-1:`RISC8_WORD_W];
                        end
                        ALU_SL: begin
                                alu_lo = a << shamt;
                        end
                        ALU_SR: begin
                                alu_lo = a >> shamt;
                        end
                        // arithmetic shift keeps the sign bit.
                        ALU_RA: begin
                                alu_lo = word_t'($signed(a) >>> shamt);
                        end
                        default: begin
                                alu_lo = '0;
                        end
                endcase
        end

endmodule

/* source/risc8_regfile.sv */
`include "risc8_defs.svh"

module risc8_regfile import risc8_pkg::*; (
        input  logic       clk,
        input  logic       rst_n,
        input  logic       exec_en,
        input  ctrl_t      ctrl,
        input  reg_addr_t  ra,
        input  reg_addr_t  rb,
        input  word_t      imm,
        input  word_t      alu_lo,
        input  word_t      alu_hi,
        input  logic [2:0] rd_sel,
        input  logic       rd_en,
        output word_t      a,
        output word_t      b,
        output word_t      rd_data
);

        word_t regs [4];
        word_t ah;
        word_t wr_data;

        assign a = regs[ra];

        // second operand.
        always_comb begin
                case (ctrl.selb)
                        SB_REG:  b = regs[rb];
                        SB_1:    b = word_t'(1);
                        SB_IMM:  b = imm;
                        default: b = '0;
                endcase
        end

        // writeback source for ra.
        always_comb begin
                case (ctrl.selr)
                        SR_IMM:  wr_data = imm;
                        SR_REG:  wr_data = regs[rb];
                        SR_ALUL: wr_data = alu_lo;
                        SR_ALUH: wr_data = ah;
                        default: wr_data = '0;
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < 4; i++) begin
                                regs[i] <= '0;
                        end
                        ah <= '0;
                end else if (exec_en) begin
                        if (ctrl.rw_en) begin
                                regs[ra] <= wr_data;
                        end
                        // mul writes ra and ah on the same edge.
                        if (ctrl.ah_en) begin
                                ah <= alu_hi;
                        end
                end
        end

        always_comb begin
                if (!rd_en) begin
                        rd_data = '0;
                end else if (rd_sel == 3'(`RISC8_ADDR_AH)) begin
                        rd_data = ah;
                end else begin
                        rd_data = regs[rd_sel[1:0]];
                end
        end

endmodule

/* source/risc8_apb_port.sv */
`include "risc8_defs.svh"

module risc8_apb_port import risc8_pkg::*; (
        input  logic                      psel,
        input  logic                      penable,
        input  logic                      pwrite,
        input  logic [`RISC8_PADDR_W-1:0] paddr,
        input  pdata_t                    pwdata,
        input  logic                      illegal,
        input  word_t                     rd_data,
        output pdata_t                    prdata,
        output logic                      pready,
        output logic                      pslverr,
        output word_t                     instr,
        output word_t                     imm,
        output logic                      exec_en,
        output logic [2:0]                rd_sel,
        output logic                      rd_en
);

        logic access;
        logic waddr_ok;
        logic raddr_ok;
        logic wr_err;

        assign access   = psel & penable;
        assign waddr_ok = (paddr == `RISC8_PADDR_W'(`RISC8_ADDR_INSTR));
        assign raddr_ok = (paddr <= `RISC8_PADDR_W'(`RISC8_ADDR_AH));

        // instruction in the low byte, immediate in the high byte.
        assign instr = pwdata[`RISC8_WORD_W-1:0];
        assign imm   = pwdata[`RISC8_PDATA_W-1:`RISC8_WORD_W];

        // zero wait states.
        assign pready = 1'b1;

        assign wr_err  = ~waddr_ok | illegal;
        assign exec_en = access & pwrite & ~wr_err;

        always_comb begin
                if (!access) begin
                        pslverr = 1'b0;
                end else if (pwrite) begin
                        pslverr = wr_err;
                end else begin
                        pslverr = ~raddr_ok;
                end
        end

        // regfile returns zero when not enabled.
        assign rd_sel = paddr[2:0];
        assign rd_en  = psel & ~pwrite & raddr_ok;
        assign prdata = {{(`RISC8_PDATA_W-`RISC8_WORD_W){1'b0}}, rd_data};

endmodule

/* source/risc8_core.sv */
`include "risc8_defs.svh"

module risc8_core import risc8_pkg::*; (
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      psel,
        input  logic                      penable,
        input  logic                      pwrite,
        input  logic [`RISC8_PADDR_W-1:0] paddr,
        input  pdata_t                    pwdata,
        output pdata_t                    prdata,
        output logic                      pready,
        output logic                      pslverr
);

        word_t      instr;
        word_t      imm;
        logic       exec_en;
        logic       illegal;
        logic [2:0] rd_sel;
        logic       rd_en;
        word_t      rd_data;
        ctrl_t      ctrl;
        reg_addr_t  ra;
        reg_addr_t  rb;
        word_t      a;
        word_t      b;
        word_t      alu_lo;
        word_t      alu_hi;

        risc8_apb_port u_port (
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .paddr   (paddr),
                .pwdata  (pwdata),
                .illegal (illegal),
                .rd_data (rd_data),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr),
                .instr   (instr),
                .imm     (imm),
                .exec_en (exec_en),
                .rd_sel  (rd_sel),
                .rd_en   (rd_en)
        );

        // decode and execute settle within the access phase.
        risc8_decoder u_dec (
                .instr   (instr),
                .ctrl    (ctrl),
                .ra      (ra),
                .rb      (rb),
                .illegal (illegal)
        );

        risc8_alu u_alu (
                .alu_op (ctrl.alu_op),
                .a      (a),
                .b      (b),
                .alu_lo (alu_lo),
                .alu_hi (alu_hi)
        );

        risc8_regfile u_rf (
                .clk     (clk),
                .rst_n   (rst_n),
                .exec_en (exec_en),
                .ctrl    (ctrl),
                .ra      (ra),
                .rb      (rb),
                .imm     (imm),
                .alu_lo  (alu_lo),
                .alu_hi  (alu_hi),
                .rd_sel  (rd_sel),
                .rd_en   (rd_en),
                .a       (a),
                .b       (b),
                .rd_data (rd_data)
        );

endmodule

/* verification/risc8_tb.sv */
`include "risc8_defs.svh"

module risc8_tb import risc8_pkg::*; ();

        localparam int half_period = 20;
        localparam int drive_dly   = 2;
        localparam int wait_limit  = 16;
        localparam logic [`RISC8_PADDR_W-1:0] instr_addr = `RISC8_ADDR_INSTR;
        localparam logic [`RISC8_PADDR_W-1:0] ah_addr    = `RISC8_ADDR_AH;

        typedef struct {
                logic [3:0]                op;
                reg_addr_t                 ra;
                reg_addr_t                 rb;
                word_t                     imm;
                logic [`RISC8_PADDR_W-1:0] addr;
                logic                      err;
                logic                      use_model;
                word_t                     exp;
        } entry_t;

        logic                      clk;
        logic                      rst_n;
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`RISC8_PADDR_W-1:0] paddr;
        pdata_t                    pwdata;
        pdata_t                    prdata;
        logic                      pready;
        logic                      pslverr;

        entry_t      stim[$];
        word_t       shadow[4];
        word_t       shadow_ah;
        logic [31:0] lfsr_state;
        int          word_errs;
        int          resp_errs;
        int          timeouts;

        risc8_core u_dut (
                .clk     (clk),
                .rst_n   (rst_n),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .paddr   (paddr),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #half_period clk = ~clk;
                end
        end

        // taps 32, 22, 2, 1.
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic rand_byte(output word_t v);
                v = '0;
                for (int i = 0; i < `RISC8_WORD_W; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        v = {v[`RISC8_WORD_W-2:0], lfsr_state[0]};
                end
        endtask

        task automatic check_word(input word_t got, input word_t exp, input string what);
                if (got !== exp) begin
                        word_errs++;
                        $display("CHECK FAILED at %0t: %s, got %02h expected %02h",
                                 $time, what, got, exp);
                end
        endtask

        task automatic check_err(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        resp_errs++;
                        $display("CHECK FAILED at %0t: %s, pslverr %b expected %b",
                                 $time, what, got, exp);
                end
        endtask

        task automatic check_ready(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        resp_errs++;
                        $display("CHECK FAILED at %0t: %s, pready %b expected %b",
                                 $time, what, got, exp);
                end
        endtask

        task automatic apb_xfer(input logic wr, input logic [`RISC8_PADDR_W-1:0] addr,
                                input pdata_t wdata, output pdata_t rdata, output logic err);
                int   cycles;
                logic done;
                done   = 1'b0;
                cycles = 0;
                rdata  = '0;
                err    = 1'b0;
                @(posedge clk);
                #drive_dly;
                psel    = 1'b1;
                penable = 1'b0;
                pwrite  = wr;
                paddr   = addr;
                pwdata  = wdata;
                @(posedge clk);
                #drive_dly;
                penable = 1'b1;
                while (!done && cycles < wait_limit) begin
                        @(posedge clk);
                        cycles++;
                        // zero wait states.
                        if (cycles == 1) begin
                                check_ready(pready, 1'b1,
                                            $sformatf("access phase at address %0d", addr));
                        end
                        if (pready) begin
                                done  = 1'b1;
                                rdata = prdata;
                                err   = pslverr;
                        end
                end
                #drive_dly;
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
                if (!done) begin
                        timeouts++;
                        $display("timeout: pready never came high at address %0d", addr);
                end
        endtask

        task automatic apb_write(input logic [`RISC8_PADDR_W-1:0] addr, input pdata_t data,
                                 output logic err);
                pdata_t unused;
                apb_xfer(1'b1, addr, data, unused, err);
        endtask

        task automatic apb_read(input logic [`RISC8_PADDR_W-1:0] addr, output pdata_t data,
                                output logic err);
                apb_xfer(1'b0, addr, '0, data, err);
        endtask

        // shadow copy of the register machine.
        task automatic model_exec(input logic [3:0] op, input reg_addr_t ra,
                                  input reg_addr_t rb, input word_t imm, output word_t res);
                logic [15:0] prod;
                word_t       x;
                word_t       y;
                int          sh;
                x   = shadow[ra];
                y   = shadow[rb];
                sh  = y[`RISC8_SHAMT_W-1:0];
                res = x;
                case (op)
                        CPY:   res = imm;
                        MOVE:  res = y;
                        ADD:   res = x + y;
                        SUB:   res = x - y;
                        AND:   res = x & y;
                        OR:    res = x | y;
                        XOR:   res = x ^ y;
                        MUL: begin
                                prod      = 16'(x) * 16'(y);
                                res       = prod[7:0];
                                shadow_ah = prod[15:8];
                        end
                        SLL:   repeat (sh) res = {res[6:0], 1'b0};
                        SRL:   repeat (sh) res = {1'b0, res[7:1]};
                        SRA:   repeat (sh) res = {res[7], res[7:1]};
                        INC:   res = x + 8'd1;
                        DEC:   res = x - 8'd1;
                        GETAH: res = shadow_ah;
                        default: res = x;
                endcase
                shadow[ra] = res;
        endtask

        task automatic push_entry(input logic [3:0] op, input reg_addr_t ra, input reg_addr_t rb,
                                  input word_t imm, input logic [`RISC8_PADDR_W-1:0] addr,
                                  input logic err, input logic use_model, input word_t exp);
                entry_t e;
                e.op        = op;
                e.ra        = ra;
                e.rb        = rb;
                e.imm       = imm;
                e.addr      = addr;
                e.err       = err;
                e.use_model = use_model;
                e.exp       = exp;
                stim.push_back(e);
        endtask

        task automatic modeled_op(input logic [3:0] op, input reg_addr_t ra, input reg_addr_t rb,
                                  input word_t imm);
                push_entry(op, ra, rb, imm, instr_addr, 1'b0, 1'b1, '0);
        endtask

        task automatic known_op(input logic [3:0] op, input reg_addr_t ra, input reg_addr_t rb,
                                input word_t imm, input word_t exp);
                push_entry(op, ra, rb, imm, instr_addr, 1'b0, 1'b0, exp);
        endtask

        task automatic faulty_op(input logic [3:0] op, input reg_addr_t ra,
                                 input logic [`RISC8_PADDR_W-1:0] addr);
                push_entry(op, ra, 2'd0, 8'h77, addr, 1'b1, 1'b0, '0);
        endtask

        task automatic load_rand(input reg_addr_t ra, input word_t set_bits, input word_t keep);
                word_t v;
                rand_byte(v);
                modeled_op(CPY, ra, 2'd0, (v & keep) | set_bits);
        endtask

        task automatic build_stim();
                logic [3:0] ops[5];
                ops = '{ADD, SUB, AND, OR, XOR};
                known_op(CPY, 2'd0, 2'd0, 8'h5a, 8'h5a);
                known_op(CPY, 2'd1, 2'd0, 8'ha5, 8'ha5);
                known_op(CPY, 2'd2, 2'd0, 8'h3c, 8'h3c);
                known_op(CPY, 2'd3, 2'd0, 8'hc3, 8'hc3);
                known_op(MOVE, 2'd0, 2'd3, 8'h00, 8'hc3);
                known_op(MOVE, 2'd2, 2'd1, 8'h00, 8'ha5);
                foreach (ops[i]) begin
                        repeat (2) begin
                                load_rand(2'd1, 8'h00, 8'hff);
                                load_rand(2'd2, 8'h00, 8'hff);
                                modeled_op(ops[i], 2'd1, 2'd2, 8'h00);
                        end
                end
                modeled_op(ADD, 2'd2, 2'd2, 8'h00);
                modeled_op(INC, 2'd1, 2'd0, 8'h00);
                modeled_op(DEC, 2'd2, 2'd0, 8'h00);
                // wraparound at the byte boundary.
                known_op(CPY, 2'd3, 2'd0, 8'hff, 8'hff);
                known_op(INC, 2'd3, 2'd0, 8'h00, 8'h00);
                known_op(DEC, 2'd3, 2'd0, 8'h00, 8'hff);
                known_op(CPY, 2'd0, 2'd0, 8'hf0, 8'hf0);
                known_op(CPY, 2'd1, 2'd0, 8'h20, 8'h20);
                known_op(ADD, 2'd0, 2'd1, 8'h00, 8'h10);
                known_op(MUL, 2'd3, 2'd3, 8'h00, 8'h01);
                known_op(GETAH, 2'd2, 2'd0, 8'h00, 8'hfe);
                repeat (3) begin
                        load_rand(2'd0, 8'h00, 8'hff);
                        load_rand(2'd3, 8'h00, 8'hff);
                        modeled_op(MUL, 2'd0, 2'd3, 8'h00);
                        modeled_op(GETAH, 2'd2, 2'd0, 8'h00);
                end
                for (int k = 0; k < 8; k++) begin
                        known_op(CPY, 2'd1, 2'd0, word_t'(k), word_t'(k));
                        load_rand(2'd0, 8'h00, 8'hff);
                        modeled_op(SLL, 2'd0, 2'd1, 8'h00);
                        load_rand(2'd0, 8'h00, 8'hff);
                        modeled_op(SRL, 2'd0, 2'd1, 8'h00);
                        load_rand(2'd0, 8'h80, 8'hff);
                        modeled_op(SRA, 2'd0, 2'd1, 8'h00);
                        load_rand(2'd2, 8'h00, 8'h7f);
                        modeled_op(SRA, 2'd2, 2'd1, 8'h00);
                end
                faulty_op(4'd14, 2'd0, instr_addr);
                faulty_op(4'd15, 2'd3, instr_addr);
                faulty_op(CPY, 2'd1, 4'd1);
        endtask

        task automatic apply_entry(input entry_t e, input int idx);
                pdata_t rdata;
                logic   err;
                word_t  exp;
                apb_write(e.addr, {e.imm, e.op, e.ra, e.rb}, err);
                check_err(err, e.err, $sformatf("entry %0d write response", idx));
                if (e.err) begin
                        exp = shadow[e.ra];
                end else begin
                        model_exec(e.op, e.ra, e.rb, e.imm, exp);
                        if (!e.use_model) begin
                                exp = e.exp;
                        end
                end
                apb_read(`RISC8_PADDR_W'(e.ra), rdata, err);
                check_err(err, 1'b0, $sformatf("entry %0d read response", idx));
                check_word(rdata[7:0], exp, $sformatf("entry %0d op %0d r%0d", idx, e.op, e.ra));
                check_word(rdata[15:8], 8'h00, $sformatf("entry %0d upper read byte", idx));
        endtask

        task automatic verify_regs(input string when);
                pdata_t rdata;
                logic   err;
                for (int i = 0; i < 4; i++) begin
                        apb_read(`RISC8_PADDR_W'(i), rdata, err);
                        check_err(err, 1'b0, $sformatf("%s read r%0d", when, i));
                        check_word(rdata[7:0], shadow[i], $sformatf("%s r%0d", when, i));
                end
                apb_read(ah_addr, rdata, err);
                check_err(err, 1'b0, $sformatf("%s read ah", when));
                check_word(rdata[7:0], shadow_ah, $sformatf("%s ah", when));
        endtask

        initial begin
                pdata_t rdata;
                logic   err;
                rst_n      = 1'b0;
                psel       = 1'b0;
                penable    = 1'b0;
                pwrite     = 1'b0;
                paddr      = '0;
                pwdata     = '0;
                word_errs  = 0;
                resp_errs  = 0;
                timeouts   = 0;
                shadow_ah  = '0;
                lfsr_state = 32'h95ce487e;
                foreach (shadow[i]) begin
                        shadow[i] = '0;
                end
                build_stim();
                repeat (4) @(posedge clk);
                #drive_dly;
                rst_n = 1'b1;
                verify_regs("after reset");
                for (int i = 0; i < stim.size(); i++) begin
                        if (timeouts != 0) begin
                                break;
                        end
                        apply_entry(stim[i], i);
                end
                // read past the map.
                apb_read(4'd9, rdata, err);
                check_err(err, 1'b1, "read of address 9");
                check_word(rdata[7:0], 8'h00, "low byte of erroring read");
                check_word(rdata[15:8], 8'h00, "high byte of erroring read");
                verify_regs("after errors");
                $display("word errors %0d, response errors %0d, timeouts %0d",
                         word_errs, resp_errs, timeouts);
                if (word_errs == 0 && resp_errs == 0 && timeouts == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule

/* tb.f */
+incdir+include
source/risc8_pkg.sv
source/risc8_decoder.sv
source/risc8_alu.sv
source/risc8_regfile.sv
source/risc8_apb_port.sv
source/risc8_core.sv
verification/risc8_tb.sv
